//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pcw_bus_core
LOG       ?= sim.log
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
src/pcw_pkg.sv
src/pcw_io_regs.sv
src/pcw_mem_mapper.sv
src/pcw_int_status.sv
src/pcw_bus_core.sv
verification/tb_pcw_bus_core.sv

//--- src/pcw_bus_core.sv
`timescale 1ns/100ps

module pcw_bus_core import pcw_pkg::*; (
    input  logic      clk_sys,
    input  logic      reset,
    input  cpu_addr_t cpu_addr,
    input  byte_t     cpu_dout,
    input  logic      io_rd,
    input  logic      io_wr,
    input  logic      mem_wr,
    input  mem_size_t memory_size,
    input  logic      ntsc,
    input  logic      vblank,
    input  logic      timer_tick,
    input  logic      fdc_int,
    input  logic      iff1,
    output ram_addr_t ram_addr,
    output byte_t     io_din,
    output byte_t     roller_ptr,
    output byte_t     yscroll,
    output logic      inverse,
    output logic      video_enable,
    output logic      motor,
    output logic      fdc_tc,
    output logic      speaker_enable,
    output logic      int_n,
    output logic      nmi_n
);

    // Paging registers to the mapper
    bank_reg_u bank0;
    bank_reg_u bank1;
    bank_reg_u bank2;
    bank_reg_u bank3;
    byte_t     lock_reg;

    // Disk interrupt routing
    logic disk_to_nmi;
    logic disk_to_int;
    logic int_mode_change;

    pcw_io_regs u_io_regs (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .io_wr           (io_wr),
        .cpu_addr        (cpu_addr),
        .cpu_dout        (cpu_dout),
        .bank0           (bank0),
        .bank1           (bank1),
        .bank2           (bank2),
        .bank3           (bank3),
        .lock_reg        (lock_reg),
        .roller_ptr      (roller_ptr),
        .yscroll         (yscroll),
        .inverse         (inverse),
        .video_enable    (video_enable),
        .disk_to_nmi     (disk_to_nmi),
        .disk_to_int     (disk_to_int),
        .int_mode_change (int_mode_change),
        .fdc_tc          (fdc_tc),
        .motor           (motor),
        .speaker_enable  (speaker_enable)
    );

    pcw_mem_mapper u_mem_mapper (
        .cpu_addr    (cpu_addr),
        .mem_wr      (mem_wr),
        .memory_size (memory_size),
        .bank0       (bank0),
        .bank1       (bank1),
        .bank2       (bank2),
        .bank3       (bank3),
        .lock_reg    (lock_reg),
        .ram_addr    (ram_addr)
    );

    pcw_int_status u_int_status (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .io_rd           (io_rd),
        .cpu_addr        (cpu_addr),
        .timer_tick      (timer_tick),
        .fdc_int         (fdc_int),
        .iff1            (iff1),
        .vblank          (vblank),
        .ntsc            (ntsc),
        .disk_to_nmi     (disk_to_nmi),
        .disk_to_int     (disk_to_int),
        .int_mode_change (int_mode_change),
        .io_din          (io_din),
        .int_n           (int_n),
        .nmi_n           (nmi_n)
    );

endmodule

//--- src/pcw_int_status.sv
`timescale 1ns/100ps

module pcw_int_status import pcw_pkg::*; (
    input  logic      clk_sys,
    input  logic      reset,
    input  logic      io_rd,            // Single cycle read strobe
    input  cpu_addr_t cpu_addr,
    input  logic      timer_tick,       // Video timer, 300 Hz
    input  logic      fdc_int,
    input  logic      iff1,             // CPU interrupt enable
    input  logic      vblank,
    input  logic      ntsc,
    input  logic      disk_to_nmi,
    input  logic      disk_to_int,
    input  logic      int_mode_change,
    output byte_t     io_din,
    output logic      int_n,
    output logic      nmi_n
);

    logic [1:0] edge_q;                 // {timer_tick, fdc_int} sampled
    logic [1:0] edge_qq;
    logic       tick_rise;
    logic       fdc_rise;
    logic       fdc_fall;

    logic       fdc_latch;              // Shown in status byte
    logic       nmi_flag;               // Pending disk NMI
    logic       timer_line;
    logic       int_line;               // Disk INT
    logic       nmi_line;
    logic [3:0] miss_count;             // Ticks since last F4 read

    logic                                  clear_busy;
    logic [$clog2(TIMER_CLEAR_CYCLES)-1:0] clear_count;

    logic lock_port_rd;
    logic status_sel;

    assign lock_port_rd = io_rd && (cpu_addr[7:0] == PORT_LOCK);
    assign status_sel   = io_rd && ((cpu_addr[7:0] == PORT_LOCK) ||
                                    (cpu_addr[7:0] == PORT_SYS_CTRL));

    // Two stage sample, edges seen one cycle after the input moves
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            edge_q  <= '0;
            edge_qq <= '0;
        end else begin
            edge_q  <= {timer_tick, fdc_int};
            edge_qq <= edge_q;
        end
    end

    assign tick_rise = edge_q[1] & ~edge_qq[1];
    assign fdc_rise  = edge_q[0] & ~edge_qq[0];
    assign fdc_fall  = ~edge_q[0] & edge_qq[0];

    // FDC status latch and NMI request
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            fdc_latch <= 1'b0;
            nmi_flag  <= 1'b0;
        end else begin
            if (fdc_rise) begin
                fdc_latch <= 1'b1;
                if (disk_to_nmi)
                    nmi_flag <= 1'b1;
            end else if (fdc_fall) begin
                fdc_latch <= 1'b0;
            end
            if (int_mode_change && !disk_to_nmi)
                nmi_flag <= 1'b0;               // INT route or disconnect drops NMI
        end
    end

    // Interrupt lines update on each timer tick
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            timer_line  <= 1'b0;
            int_line    <= 1'b0;
            nmi_line    <= 1'b0;
            miss_count  <= '0;
            clear_busy  <= 1'b0;
            clear_count <= '0;
        end else begin
            if (tick_rise) begin
                if (miss_count != MISS_MAX)
                    miss_count <= miss_count + 4'd1;    // Saturates
                timer_line <= iff1;
                nmi_line   <= nmi_flag;                 // Held while flag stays set
                int_line   <= disk_to_int & fdc_latch & iff1;
            end
            // F4 read acknowledges the timer after a delay
            if (lock_port_rd) begin
                clear_busy  <= 1'b1;
                clear_count <= '0;                      // Restart on every read
            end else if (clear_busy) begin
                if (clear_count == $bits(clear_count)'(TIMER_CLEAR_CYCLES - 1)) begin
                    clear_busy <= 1'b0;
                    timer_line <= 1'b0;
                    miss_count <= '0;
                end else begin
                    clear_count <= clear_count + 1'b1;
                end
            end
            if (int_mode_change && !disk_to_int)
                int_line <= 1'b0;                       // NMI route or disconnect
        end
    end

    assign nmi_n = ~nmi_line;
    // No INT while an NMI is outstanding
    assign int_n = nmi_line | ~(int_line | timer_line);

    // Status byte for F4 and F8, bus floats elsewhere
    assign io_din = status_sel ? {1'b0, vblank, fdc_latch, ~ntsc, miss_count} : BUS_FLOAT;

endmodule

//--- src/pcw_io_regs.sv
`timescale 1ns/100ps

module pcw_io_regs import pcw_pkg::*; (
    input  logic      clk_sys,
    input  logic      reset,
    input  logic      io_wr,            // Single cycle write strobe
    input  cpu_addr_t cpu_addr,
    input  byte_t     cpu_dout,
    output bank_reg_u bank0,
    output bank_reg_u bank1,
    output bank_reg_u bank2,
    output bank_reg_u bank3,
    output byte_t     lock_reg,
    output byte_t     roller_ptr,
    output byte_t     yscroll,
    output logic      inverse,
    output logic      video_enable,
    output logic      disk_to_nmi,
    output logic      disk_to_int,
    output logic      int_mode_change,  // Pulse when disk routing changes
    output logic      fdc_tc,
    output logic      motor,
    output logic      speaker_enable
);

    byte_t port_sel;
    assign port_sel = cpu_addr[7:0];    // Only the low byte decodes

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            bank0           <= BANK_RESET0;
            bank1           <= BANK_RESET1;
            bank2           <= BANK_RESET2;
            bank3           <= BANK_RESET3;
            lock_reg        <= LOCK_RESET;
            roller_ptr      <= '0;
            yscroll         <= '0;
            inverse         <= INVERSE_RESET[7];
            video_enable    <= INVERSE_RESET[6];
            disk_to_nmi     <= 1'b0;
            disk_to_int     <= 1'b0;
            int_mode_change <= 1'b0;
            fdc_tc          <= 1'b0;
            motor           <= 1'b0;
            speaker_enable  <= 1'b0;
        end else begin
            int_mode_change <= 1'b0;            // Default, pulses for one cycle
            if (io_wr) begin
                case (port_sel)
                    PORT_BANK0:   bank0      <= cpu_dout;
                    PORT_BANK1:   bank1      <= cpu_dout;
                    PORT_BANK2:   bank2      <= cpu_dout;
                    PORT_BANK3:   bank3      <= cpu_dout;
                    PORT_LOCK:    lock_reg   <= cpu_dout;
                    PORT_ROLLER:  roller_ptr <= cpu_dout;
                    PORT_YSCROLL: yscroll    <= cpu_dout;
                    PORT_INVERSE: begin
                        inverse      <= cpu_dout[7];
                        video_enable <= cpu_dout[6];
                    end
                    PORT_SYS_CTRL: begin
                        // System control command in low nibble
                        case (cpu_dout[3:0])
                            CMD_DISK_NMI: begin
                                disk_to_nmi <= 1'b1;
                                disk_to_int <= 1'b0;    // Routes are exclusive
                            end
                            CMD_DISK_INT: begin
                                disk_to_int     <= 1'b1;
                                disk_to_nmi     <= 1'b0;
                                int_mode_change <= 1'b1;
                            end
                            CMD_DISK_OFF: begin         // Disconnect disk interrupt
                                disk_to_int     <= 1'b0;
                                disk_to_nmi     <= 1'b0;
                                int_mode_change <= 1'b1;
                            end
                            CMD_TC_SET:    fdc_tc         <= 1'b1;
                            CMD_TC_CLR:    fdc_tc         <= 1'b0;
                            CMD_MOTOR_ON:  motor          <= 1'b1;
                            CMD_MOTOR_OFF: motor          <= 1'b0;
                            CMD_SPK_ON:    speaker_enable <= 1'b1;
                            CMD_SPK_OFF:   speaker_enable <= 1'b0;
                            default: ;                  // Bootstrap end, reset etc ignored
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- src/pcw_mem_mapper.sv
`timescale 1ns/100ps

module pcw_mem_mapper import pcw_pkg::*; (
    input  cpu_addr_t cpu_addr,
    input  logic      mem_wr,           // High during a memory write
    input  mem_size_t memory_size,
    input  bank_reg_u bank0,
    input  bank_reg_u bank1,
    input  bank_reg_u bank2,
    input  bank_reg_u bank3,
    input  byte_t     lock_reg,         // Bits 7:4 lock reads per page
    output ram_addr_t ram_addr
);

    logic [1:0]            page;
    logic [PAGE_BITS-1:0]  offset;
    bank_reg_u             bank_sel;
    logic                  read_locked;
    logic [BLOCK_BITS-1:0] block_mask;
    logic [BLOCK_BITS-1:0] pcw_block;
    logic [2:0]            cpc_block;

    assign page   = cpu_addr[15:14];
    assign offset = cpu_addr[PAGE_BITS-1:0];

    // Bank register for the current 16K page
    always_comb begin
        case (page)
            2'd0:    bank_sel = bank0;
            2'd1:    bank_sel = bank1;
            2'd2:    bank_sel = bank2;
            default: bank_sel = bank3;
        endcase
    end

    assign read_locked = lock_reg[{1'b1, page}];    // Bit 4 plus page

    // Highest usable block depends on fitted RAM
    always_comb begin
        case (memory_size)
            MEM_256K: block_mask = 7'h0F;
            MEM_512K: block_mask = 7'h1F;
            MEM_1M:   block_mask = 7'h3F;
            MEM_2M:   block_mask = 7'h7F;
            default:  block_mask = 7'h7F;
        endcase
    end

    assign pcw_block = bank_sel.pcw.block & block_mask;

    // CPC mode splits reads and writes, lock forces reads to the write block
    assign cpc_block = (mem_wr || read_locked) ? bank_sel.cpc.write_block
                                               : bank_sel.cpc.read_block;

    always_comb begin
        if (bank_sel.pcw.pcw_mode)
            ram_addr = {pcw_block, offset};
        else
            ram_addr = {{(BLOCK_BITS-3){1'b0}}, cpc_block, offset};  // Low 128K only
    end

endmodule

//--- src/pcw_pkg.sv
package pcw_pkg;

    // Block number and page offset widths
    localparam int BLOCK_BITS = 7;              // Up to 128 blocks of 16K
    localparam int PAGE_BITS  = 14;             // Offset inside a 16K page

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] cpu_addr_t;
    typedef logic [BLOCK_BITS+PAGE_BITS-1:0] ram_addr_t;   // 2 MB space
    typedef logic [1:0]  mem_size_t;

    // Bank register as a PCW block number
    typedef struct packed {
        logic                  pcw_mode;        // 1 for PCW paging
        logic [BLOCK_BITS-1:0] block;
    } bank_pcw_t;

    // Same byte as CPC read and write blocks
    typedef struct packed {
        logic       pcw_mode;                   // 0 for CPC paging
        logic [2:0] read_block;
        logic       spare;
        logic [2:0] write_block;
    } bank_cpc_t;

    typedef union packed {
        bank_pcw_t pcw;
        bank_cpc_t cpc;
    } bank_reg_u;

    // Installed memory size codes
    localparam mem_size_t MEM_256K = 2'd0;
    localparam mem_size_t MEM_512K = 2'd1;
    localparam mem_size_t MEM_1M   = 2'd2;
    localparam mem_size_t MEM_2M   = 2'd3;

    // I/O port numbers, low address byte
    localparam byte_t PORT_BANK0    = 8'hF0;
    localparam byte_t PORT_BANK1    = 8'hF1;
    localparam byte_t PORT_BANK2    = 8'hF2;
    localparam byte_t PORT_BANK3    = 8'hF3;
    localparam byte_t PORT_LOCK     = 8'hF4;    // CPC read lock, timer clear on read
    localparam byte_t PORT_ROLLER   = 8'hF5;
    localparam byte_t PORT_YSCROLL  = 8'hF6;
    localparam byte_t PORT_INVERSE  = 8'hF7;
    localparam byte_t PORT_SYS_CTRL = 8'hF8;

    // Port F8 command codes, low nibble
    localparam logic [3:0] CMD_DISK_NMI  = 4'd2;
    localparam logic [3:0] CMD_DISK_INT  = 4'd3;
    localparam logic [3:0] CMD_DISK_OFF  = 4'd4;
    localparam logic [3:0] CMD_TC_SET    = 4'd5;
    localparam logic [3:0] CMD_TC_CLR    = 4'd6;
    localparam logic [3:0] CMD_MOTOR_ON  = 4'd9;
    localparam logic [3:0] CMD_MOTOR_OFF = 4'd10;
    localparam logic [3:0] CMD_SPK_ON    = 4'd11;
    localparam logic [3:0] CMD_SPK_OFF   = 4'd12;

    // Register values after reset
    localparam byte_t BANK_RESET0   = 8'h80;    // PCW mode, block 0
    localparam byte_t BANK_RESET1   = 8'h81;
    localparam byte_t BANK_RESET2   = 8'h82;
    localparam byte_t BANK_RESET3   = 8'h83;
    localparam byte_t LOCK_RESET    = 8'hF1;
    localparam byte_t INVERSE_RESET = 8'h80;    // Inverse on, video off

    localparam byte_t BUS_FLOAT = 8'hFF;        // Undriven data bus

    // Timer interrupt handling
    localparam int         TIMER_CLEAR_CYCLES = 32;
    localparam logic [3:0] MISS_MAX           = 4'd15;

endpackage

//--- verification/tb_pcw_bus_core.sv
`timescale 1ns/100ps

module tb_pcw_bus_core import pcw_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = 4000;     // Tests take under 2000 cycles

    logic      clk_sys, reset, io_rd, io_wr, mem_wr;
    logic      ntsc, vblank, timer_tick, fdc_int, iff1;
    cpu_addr_t cpu_addr;
    byte_t     cpu_dout, io_din, roller_ptr, yscroll;
    mem_size_t memory_size;
    ram_addr_t ram_addr;
    logic      inverse, video_enable, motor, fdc_tc, speaker_enable, int_n, nmi_n;

    int          errors;
    int          cycle_count;
    logic [31:0] lcg_state;

    pcw_bus_core DUT (.*);

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected status byte, top bit first
    function automatic byte_t status_byte(logic vb, logic latch, logic nt, logic [3:0] miss);
        return {1'b0, vb, latch, ~nt, miss};
    endfunction

    task automatic check_addr(string name, ram_addr_t exp, ram_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(string name, byte_t exp, byte_t act);
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic write_port(byte_t port, byte_t data);
        @(posedge clk_sys);
        #2;
        cpu_addr = {8'h00, port};
        cpu_dout = data;
        io_wr    = 1'b1;
        @(posedge clk_sys);     // Register loads here
        #2;
        io_wr = 1'b0;
    endtask

    task automatic read_status(byte_t port, logic vb_exp, logic latch, logic [3:0] miss);
        @(posedge clk_sys);
        #2;
        cpu_addr = {8'h00, port};
        io_rd    = 1'b1;
        #10;
        check_byte("io_din", status_byte(vb_exp, latch, ntsc, miss), io_din);
        @(posedge clk_sys);
        #2;
        io_rd = 1'b0;
    endtask

    // Read of a port without status, bus floats
    task automatic read_float(byte_t port);
        @(posedge clk_sys);
        #2;
        cpu_addr = {8'h00, port};
        io_rd    = 1'b1;
        #10;
        check_byte("io_din", 8'hFF, io_din);
        @(posedge clk_sys);
        #2;
        io_rd = 1'b0;
    endtask

    // Random offset in a page, expected block from the caller
    task automatic check_map(logic [1:0] page, logic wr, logic [BLOCK_BITS-1:0] block);
        logic [31:0] r;
        r = next_random();
        @(posedge clk_sys);
        #2;
        cpu_addr = {page, r[PAGE_BITS-1:0]};
        mem_wr   = wr;
        #10;
        check_addr("ram_addr", {block, r[PAGE_BITS-1:0]}, ram_addr);
        mem_wr = 1'b0;
    endtask

    task automatic pulse_tick();
        @(posedge clk_sys);
        #2 timer_tick = 1'b1;
        @(posedge clk_sys);
        #2 timer_tick = 1'b0;
        @(posedge clk_sys);     // Second edge after the rise, lines updated
        #2;
    endtask

    task automatic set_fdc(logic level);
        @(posedge clk_sys);
        #2 fdc_int = level;
        repeat (2) @(posedge clk_sys);
        #2;
    endtask

    // Port F8 codes with no command
    task automatic write_unknown_cmds(logic [3:0] hi);
        for (int c = 0; c < 16; c++) begin
            if (c < 2 || c == 7 || c == 8 || c > 12)
                write_port(PORT_SYS_CTRL, {hi, 4'(c)});
        end
    endtask

    task automatic test_reset_defaults();
        check_bit("inverse", 1'b1, inverse);
        check_bit("video_enable", 1'b0, video_enable);
        check_bit("fdc_tc", 1'b0, fdc_tc);
        check_bit("motor", 1'b0, motor);
        check_bit("speaker_enable", 1'b0, speaker_enable);
        check_bit("int_n", 1'b1, int_n);
        check_bit("nmi_n", 1'b1, nmi_n);
        check_byte("io_din", 8'hFF, io_din);            // No read, bus floats
        for (int p = 0; p < 4; p++)
            check_map(2'(p), 1'b0, 7'(p));              // Page n is block n
        read_status(PORT_SYS_CTRL, 1'b0, 1'b0, 4'd0);
        read_float(PORT_ROLLER);
    endtask

    task automatic test_pcw_paging();
        logic [31:0]           r;
        logic [BLOCK_BITS-1:0] mask;
        for (int s = 0; s < 4; s++) begin
            memory_size = mem_size_t'(s);
            mask        = 7'((1 << (4 + s)) - 1);       // 4 to 7 block bits
            for (int p = 0; p < 4; p++) begin
                r = next_random();
                write_port(8'(PORT_BANK0 + p), {1'b1, r[6:0]});
                check_map(2'(p), r[8], r[6:0] & mask);  // Direction ignored
            end
        end
    endtask

    task automatic test_cpc_paging();
        logic [31:0] r;
        logic [2:0]  rb;
        for (int p = 0; p < 4; p++) begin
            r  = next_random();
            rb = r[2:0];
            write_port(PORT_LOCK, 8'h00);
            write_port(8'(PORT_BANK0 + p), {1'b0, rb, r[3], ~rb});  // Write block differs
            check_map(2'(p), 1'b1, {4'b0, ~rb});
            check_map(2'(p), 1'b0, {4'b0, rb});
            write_port(PORT_LOCK, 8'(8'h10 << p));      // Lock reads of this page
            check_map(2'(p), 1'b0, {4'b0, ~rb});
        end
    endtask

    task automatic test_regs_and_commands();
        logic [31:0] r;
        r = next_random();
        write_port(PORT_ROLLER, r[7:0]);
        check_byte("roller_ptr", r[7:0], roller_ptr);
        write_port(PORT_YSCROLL, r[15:8]);
        check_byte("yscroll", r[15:8], yscroll);
        write_port(PORT_INVERSE, 8'h40);
        check_bit("inverse", 1'b0, inverse);
        check_bit("video_enable", 1'b1, video_enable);
        write_port(PORT_SYS_CTRL, {r[19:16], CMD_TC_SET});     // Upper nibble ignored
        write_port(PORT_SYS_CTRL, {r[23:20], CMD_MOTOR_ON});
        write_port(PORT_SYS_CTRL, {r[27:24], CMD_SPK_ON});
        write_unknown_cmds(r[31:28]);
        check_bit("fdc_tc", 1'b1, fdc_tc);
        check_bit("motor", 1'b1, motor);
        check_bit("speaker_enable", 1'b1, speaker_enable);
        write_port(PORT_SYS_CTRL, {4'h0, CMD_TC_CLR});
        check_bit("fdc_tc", 1'b0, fdc_tc);
        check_bit("motor", 1'b1, motor);
        write_port(PORT_SYS_CTRL, {4'h0, CMD_MOTOR_OFF});
        write_port(PORT_SYS_CTRL, {4'h0, CMD_SPK_OFF});
        check_bit("motor", 1'b0, motor);
        check_bit("speaker_enable", 1'b0, speaker_enable);
        write_unknown_cmds(r[31:28]);                   // Nothing set either
        check_bit("fdc_tc", 1'b0, fdc_tc);
        check_bit("motor", 1'b0, motor);
        check_bit("speaker_enable", 1'b0, speaker_enable);
    endtask

    task automatic test_timer();
        logic [3:0] miss;
        pulse_tick();                                   // iff1 still low
        check_bit("int_n", 1'b1, int_n);
        miss = 4'd1;
        iff1 = 1'b1;
        for (int i = 0; i < 18; i++) begin
            pulse_tick();
            if (miss != 4'd15)
                miss = miss + 4'd1;
            check_bit("int_n", 1'b0, int_n);
        end
        vblank = 1'b1;
        ntsc   = 1'b1;
        read_status(PORT_SYS_CTRL, 1'b1, 1'b0, miss);
        vblank = 1'b0;
        ntsc   = 1'b0;
        read_status(PORT_LOCK, 1'b0, 1'b0, 4'd15);      // Starts the timer clear
        repeat (20) @(posedge clk_sys);
        #2;
        check_bit("int_n", 1'b0, int_n);                // Clear still counting
        repeat (20) @(posedge clk_sys);
        #2;
        check_bit("int_n", 1'b1, int_n);
        read_status(PORT_SYS_CTRL, 1'b0, 1'b0, 4'd0);
    endtask

    task automatic test_disk_routing();
        write_port(PORT_SYS_CTRL, {4'h0, CMD_DISK_NMI});
        set_fdc(1'b1);
        read_status(PORT_SYS_CTRL, 1'b0, 1'b1, 4'd0);
        check_bit("nmi_n", 1'b1, nmi_n);                // Waits for a tick
        pulse_tick();
        check_bit("nmi_n", 1'b0, nmi_n);
        check_bit("int_n", 1'b1, int_n);                // Masked by the NMI
        write_port(PORT_SYS_CTRL, {4'h0, CMD_DISK_INT});
        pulse_tick();
        check_bit("nmi_n", 1'b1, nmi_n);
        check_bit("int_n", 1'b0, int_n);
        read_status(PORT_LOCK, 1'b0, 1'b1, 4'd2);
        repeat (40) @(posedge clk_sys);
        #2;
        check_bit("int_n", 1'b0, int_n);                // Disk INT outlives timer clear
        set_fdc(1'b0);
        read_status(PORT_SYS_CTRL, 1'b0, 1'b0, 4'd0);
        write_port(PORT_SYS_CTRL, {4'h0, CMD_DISK_OFF});
        @(posedge clk_sys);
        #2;
        check_bit("int_n", 1'b1, int_n);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk_sys);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, tests did not complete", MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        errors      = 0;
        lcg_state   = 32'hb6f489c2;
        clk_sys     = 1'b0;
        reset       = 1'b1;
        cpu_addr    = '0;
        cpu_dout    = '0;
        io_rd       = 1'b0;
        io_wr       = 1'b0;
        mem_wr      = 1'b0;
        memory_size = MEM_2M;
        ntsc        = 1'b0;
        vblank      = 1'b0;
        timer_tick  = 1'b0;
        fdc_int     = 1'b0;
        iff1        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #2 reset = 1'b0;
        test_reset_defaults();
        test_pcw_paging();
        test_cpc_paging();
        test_regs_and_commands();
        test_timer();
        test_disk_routing();
        $display("Checks done, %0d errors", errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
